/* hw/conv_pkg.sv */
// widths are fixed for 8-bit signed taps; the bias is only meaningful on a tap with last set
`default_nettype none

package conv_pkg;

  ////////////////////
  // widths and scaling
  ////////////////////

  localparam int DATA_W     = 8;   // feature, weight and bias
  localparam int PROD_W     = 16;  // signed 8x8 product
  localparam int ACC_W      = 28;  // window sum and adder width
  localparam int CLA_GROUPS = 7;   // 4-bit groups in the 28-bit adder
  localparam int FRAC_SHIFT = 6;   // binary point of the window sum
  localparam int ACT_MAX    = 127; // activation ceiling

  ////////////////////
  // scalar types
  ////////////////////

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [PROD_W-1:0] prod_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic        [DATA_W-1:0] act_t;  // unsigned after the clamp

  ////////////////////
  // beat structs
  ////////////////////

  // input beat, one per tap
  typedef struct packed {
    data_t feat;
    data_t weight;
    data_t bias;    // read only when last is set
    logic  last;    // closes the window
  } tap_t;

  // sideband riding alongside the product
  typedef struct packed {
    logic  last;
    data_t bias;
  } tap_tag_t;

  typedef struct packed {
    logic     valid;
    tap_tag_t tag;
    prod_t    prod;
  } prod_beat_t;

  // valid only for a completed window
  typedef struct packed {
    logic  valid;
    data_t bias;
    acc_t  sum;
  } sum_beat_t;

endpackage

`default_nettype wire

/* hw/cla_block4.sv */
// one 4-bit lookahead group; no carry-out, the parent carry unit works from group_p/group_g
`timescale 1ns/100ps
`default_nettype none

module cla_block4 (
  input  wire  [3:0] a,
  input  wire  [3:0] b,
  input  wire        carry_in,
  output logic [3:0] sum,
  output logic       group_p,
  output logic       group_g
);

  logic [3:0] bit_p;  // per-bit propagate
  logic [3:0] bit_g;  // per-bit generate
  logic [3:0] carry;  // carry into each bit

  assign bit_p = a ^ b;
  assign bit_g = a & b;

  // lookahead carries rippled inside the group
  assign carry[0] = carry_in;
  assign carry[1] = bit_g[0] | (bit_p[0] & carry[0]);
  assign carry[2] = bit_g[1] | (bit_p[1] & carry[1]);
  assign carry[3] = bit_g[2] | (bit_p[2] & carry[2]);

  assign sum = bit_p ^ carry;

  // group terms for the next level
  assign group_p = &bit_p;
  assign group_g = bit_g[3]
                 | (bit_p[3] & bit_g[2])
                 | (bit_p[3] & bit_p[2] & bit_g[1])
                 | (bit_p[3] & bit_p[2] & bit_p[1] & bit_g[0]);

endmodule

`default_nettype wire

/* hw/cla_adder.sv */
// 28-bit add only, carry-in fixed at zero and carry-out dropped, so the sum wraps
`timescale 1ns/100ps
`default_nettype none

module cla_adder (
  input  wire conv_pkg::acc_t a,
  input  wire conv_pkg::acc_t b,
  output wire conv_pkg::acc_t sum
);

  wire  [conv_pkg::CLA_GROUPS-1:0] grp_p;  // group propagate
  wire  [conv_pkg::CLA_GROUPS-1:0] grp_g;  // group generate
  logic [conv_pkg::CLA_GROUPS-1:0] grp_c;  // carry into each group
  logic                            lo_g;   // generate of groups 0 to 3

  for (genvar i = 0; i < conv_pkg::CLA_GROUPS; i++) begin : g_grp
    cla_block4 cla_block4_inst (
      .a        (a[4*i +: 4]),
      .b        (b[4*i +: 4]),
      .carry_in (grp_c[i]),
      .sum      (sum[4*i +: 4]),
      .group_p  (grp_p[i]),
      .group_g  (grp_g[i])
    );
  end

  ////////////////////
  // carry unit
  ////////////////////

  // first level, groups 0 to 3, carry-in is zero
  assign grp_c[0] = 1'b0;
  assign grp_c[1] = grp_g[0];
  assign grp_c[2] = grp_g[1] | (grp_p[1] & grp_g[0]);
  assign grp_c[3] = grp_g[2] | (grp_p[2] & grp_g[1]) | (grp_p[2] & grp_p[1] & grp_g[0]);

  assign lo_g = grp_g[3]
              | (grp_p[3] & grp_g[2])
              | (grp_p[3] & grp_p[2] & grp_g[1])
              | (grp_p[3] & grp_p[2] & grp_p[1] & grp_g[0]);

  // second level, groups 4 to 6 fed by the lower block
  assign grp_c[4] = lo_g;
  assign grp_c[5] = grp_g[4] | (grp_p[4] & lo_g);
  assign grp_c[6] = grp_g[5] | (grp_p[5] & grp_g[4]) | (grp_p[5] & grp_p[4] & lo_g);

endmodule

`default_nettype wire

/* hw/mag_multiplier.sv */
// signed 8x8 multiply, input register plus 8 stages; every stage holds while advance is low
`timescale 1ns/100ps
`default_nettype none

module mag_multiplier (
  input  wire                 clk,
  input  wire                 rstn,
  input  wire                 advance,
  input  wire                 in_valid,
  input  wire conv_pkg::tap_t in_tap,
  output conv_pkg::prod_beat_t prod_beat
);

  logic [8:0]         valid_pipe;      // [0] input register, [n] stage n
  conv_pkg::tap_tag_t tag_pipe [1:8];
  logic [7:1]         sign_pipe;       // sign of the product
  conv_pkg::tap_t     tap_q;

  logic [7:0]  a_mag;
  logic [7:0]  b_mag;
  logic [7:0]  pp_s1 [8];    // gated partial products
  logic [5:0]  lsb_s2 [4];
  logic [2:0]  hia_s2 [4];
  logic [3:0]  hib_s2 [4];
  logic [9:0]  pair_s3 [4];
  logic [7:0]  lsb_s4 [2];
  logic [2:0]  hia_s4 [2];
  logic [4:0]  hib_s4 [2];
  logic [11:0] quad_s5 [2];
  logic [9:0]  lsb_s6;
  logic [2:0]  hia_s6;
  logic [6:0]  hib_s6;
  logic [15:0] mag_s7;       // unsigned product
  conv_pkg::prod_t prod_s8;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_pipe <= '0;
    end else if (advance) begin
      valid_pipe <= {valid_pipe[7:0], in_valid};  // bubbles shift down too
    end
  end

  // sideband follows the data stage by stage
  always_ff @(posedge clk) begin
    if (advance) begin
      tap_q       <= in_tap;
      tag_pipe[1] <= '{last: tap_q.last, bias: tap_q.bias};
      for (int i = 2; i <= 8; i++) begin
        tag_pipe[i] <= tag_pipe[i-1];
      end
      sign_pipe[1]   <= tap_q.feat[7] ^ tap_q.weight[7];
      sign_pipe[7:2] <= sign_pipe[6:1];
    end
  end

  ////////////////////
  // stage 1, partial products
  ////////////////////

  assign a_mag = tap_q.feat[7]   ? ~tap_q.feat + 8'd1   : tap_q.feat;    // -128 maps to 128
  assign b_mag = tap_q.weight[7] ? ~tap_q.weight + 8'd1 : tap_q.weight;

  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < 8; i++) begin
        pp_s1[i] <= b_mag[i] ? a_mag : 8'd0;
      end
    end
  end

  ////////////////////
  // stages 2 and 3, pairs at shift 1
  ////////////////////

  always_ff @(posedge clk) begin
    if (advance) begin
      for (int k = 0; k < 4; k++) begin
        lsb_s2[k] <= pp_s1[2*k][4:0] + {pp_s1[2*k+1][3:0], 1'b0};
        hia_s2[k] <= pp_s1[2*k][7:5];
        hib_s2[k] <= pp_s1[2*k+1][7:4];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      for (int k = 0; k < 4; k++) begin
        pair_s3[k] <= {{2'b00, hia_s2[k]} + {1'b0, hib_s2[k]} + lsb_s2[k][5], lsb_s2[k][4:0]};
      end
    end
  end

  ////////////////////
  // stages 4 to 7, shifts of 2 and 4
  ////////////////////

  always_ff @(posedge clk) begin
    if (advance) begin
      for (int j = 0; j < 2; j++) begin
        lsb_s4[j] <= pair_s3[2*j][6:0] + {pair_s3[2*j+1][4:0], 2'b00};
        hia_s4[j] <= pair_s3[2*j][9:7];
        hib_s4[j] <= pair_s3[2*j+1][9:5];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      for (int j = 0; j < 2; j++) begin
        quad_s5[j] <= {{2'b00, hia_s4[j]} + hib_s4[j] + lsb_s4[j][7], lsb_s4[j][6:0]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      lsb_s6 <= quad_s5[0][8:0] + {quad_s5[1][4:0], 4'b0000};
      hia_s6 <= quad_s5[0][11:9];
      hib_s6 <= quad_s5[1][11:5];
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      mag_s7 <= {{4'b0000, hia_s6} + hib_s6 + lsb_s6[9], lsb_s6[8:0]};
    end
  end

  // stage 8, sign restored
  always_ff @(posedge clk) begin
    if (advance) begin
      prod_s8 <= sign_pipe[7] ? ~mag_s7 + 16'd1 : mag_s7;
    end
  end

  always_comb begin
    prod_beat.valid = valid_pipe[8];
    prod_beat.tag   = tag_pipe[8];
    prod_beat.prod  = prod_s8;
  end

endmodule

`default_nettype wire

/* hw/mac_accumulator.sv */
// window sum wraps at 28 bits; a window starts on the first valid tap after a last tap
`timescale 1ns/100ps
`default_nettype none

module mac_accumulator (
  input  wire                       clk,
  input  wire                       rstn,
  input  wire                       advance,
  input  wire conv_pkg::prod_beat_t prod_beat,
  output conv_pkg::sum_beat_t       sum_beat
);

  logic            window_open;  // low means the next tap starts a window
  logic            sum_valid;
  conv_pkg::data_t bias_q;
  conv_pkg::acc_t  run_sum;
  conv_pkg::acc_t  prod_ext;
  conv_pkg::acc_t  base;         // zero at window start
  wire conv_pkg::acc_t next_sum;

  assign prod_ext = {{(conv_pkg::ACC_W - conv_pkg::PROD_W){prod_beat.prod[conv_pkg::PROD_W-1]}},
                     prod_beat.prod};
  assign base     = window_open ? run_sum : '0;

  cla_adder acc_adder_inst (
    .a   (prod_ext),
    .b   (base),
    .sum (next_sum)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      window_open <= 1'b0;
      sum_valid   <= 1'b0;
    end else if (advance) begin
      sum_valid <= prod_beat.valid & prod_beat.tag.last;  // one pulse per window
      if (prod_beat.valid) begin
        window_open <= !prod_beat.tag.last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance && prod_beat.valid) begin
      run_sum <= next_sum;
      bias_q  <= prod_beat.tag.bias;
    end
  end

  always_comb begin
    sum_beat.valid = sum_valid;
    sum_beat.bias  = bias_q;
    sum_beat.sum   = run_sum;
  end

endmodule

`default_nettype wire

/* hw/bias_relu_quant.sv */
// output is 0..127 only; sums beyond the 28-bit range wrap before the clamp
`timescale 1ns/100ps
`default_nettype none

module bias_relu_quant (
  input  wire                      clk,
  input  wire                      rstn,
  input  wire                      advance,
  input  wire conv_pkg::sum_beat_t sum_beat,
  output conv_pkg::act_t           out_act,
  output logic                     out_valid
);

  conv_pkg::acc_t bias_ext;  // bias at the binary point of the sum
  conv_pkg::act_t act_next;
  wire conv_pkg::acc_t total;

  assign bias_ext = {{(conv_pkg::ACC_W - conv_pkg::DATA_W - conv_pkg::FRAC_SHIFT)
                       {sum_beat.bias[conv_pkg::DATA_W-1]}},
                     sum_beat.bias,
                     {conv_pkg::FRAC_SHIFT{1'b0}}};

  cla_adder bias_adder_inst (
    .a   (sum_beat.sum),
    .b   (bias_ext),
    .sum (total)
  );

  // clamp to zero, then saturate above the 7-bit integer range
  always_comb begin
    if (total[conv_pkg::ACC_W-1]) begin
      act_next = '0;
    end else if (|total[conv_pkg::ACC_W-2 : conv_pkg::FRAC_SHIFT+conv_pkg::DATA_W-1]) begin
      act_next = conv_pkg::act_t'(conv_pkg::ACT_MAX);
    end else begin
      act_next = {1'b0, total[conv_pkg::FRAC_SHIFT+conv_pkg::DATA_W-2 : conv_pkg::FRAC_SHIFT]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= sum_beat.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      out_act <= act_next;  // held while the consumer stalls
    end
  end

endmodule

`default_nettype wire

/* hw/conv_mac_top.sv */
// a held output stalls the whole pipeline; last tap at edge E gives out_valid after E+10
`timescale 1ns/100ps
`default_nettype none

module conv_mac_top (
  input  wire                 clk,
  input  wire                 rstn,
  input  wire conv_pkg::tap_t in_tap,
  input  wire                 in_valid,
  output logic                in_ready,
  output wire conv_pkg::act_t out_act,
  output wire                 out_valid,
  input  wire                 out_ready
);

  logic                 advance;    // one enable for every stage
  conv_pkg::prod_beat_t prod_beat;
  conv_pkg::sum_beat_t  sum_beat;

  assign advance  = !out_valid || out_ready;
  assign in_ready = advance;

  mag_multiplier mag_multiplier_inst (
    .clk       (clk),
    .rstn      (rstn),
    .advance   (advance),
    .in_valid  (in_valid),
    .in_tap    (in_tap),
    .prod_beat (prod_beat)
  );

  mac_accumulator mac_accumulator_inst (
    .clk       (clk),
    .rstn      (rstn),
    .advance   (advance),
    .prod_beat (prod_beat),
    .sum_beat  (sum_beat)
  );

  bias_relu_quant bias_relu_quant_inst (
    .clk       (clk),
    .rstn      (rstn),
    .advance   (advance),
    .sum_beat  (sum_beat),
    .out_act   (out_act),
    .out_valid (out_valid)
  );

endmodule

`default_nettype wire

/* test/conv_mac_ref.svh */
// expected activation of one window of at most 9 taps; included inside the testbench module
`ifndef CONV_MAC_REF_SVH
`define CONV_MAC_REF_SVH

// exact integer model: sum of products plus bias*64, then clamp and scale
function automatic conv_pkg::act_t expected_act(input int feats[9], input int weights[9],
                                                input int taps, input int bias);
  longint total;
  int     i;
  total = longint'(bias) * 64;  // bias sits at the binary point
  for (i = 0; i < taps; i++) begin
    total += longint'(feats[i]) * longint'(weights[i]);
  end
  if (total < 0) begin
    return 8'd0;  // negative clamps to zero
  end else if (total >= 8192) begin
    return 8'd127;  // above the 7-bit range
  end else begin
    return conv_pkg::act_t'(total / 64);
  end
endfunction

`endif

/* test/conv_mac_tb.sv */
// single clock testbench; windows are limited to 9 taps and the run stops at the first mismatch
`timescale 1ns/100ps
`default_nettype none

module conv_mac_tb;

  logic           clk;
  logic           rstn;
  conv_pkg::tap_t in_tap;
  logic           in_valid;
  logic           in_ready;
  conv_pkg::act_t out_act;
  logic           out_valid;
  logic           out_ready;

  integer         seed = 32'hbb23_a66f;
  conv_pkg::tap_t stim_q [$];
  int             phase_q [$];      // 0 directed, 1 random gaps, 2 back-pressure
  conv_pkg::act_t exp_q [$];        // scoreboard
  int             windows_total = 0;
  int             outputs_seen = 0;
  bit             stim_ready = 1'b0;
  int             win_feat [9];
  int             win_weight [9];
  int             win_len = 0;

  `include "conv_mac_ref.svh"

  conv_mac_top conv_mac_top_inst (
    .clk       (clk),
    .rstn      (rstn),
    .in_tap    (in_tap),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_act   (out_act),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // checks
  ////////////////////

  task automatic check_act(input conv_pkg::act_t actual, input conv_pkg::act_t expected,
                           input string what);
    if (actual !== expected) begin
      $display("FAIL %0t: %s, out_act %0d, expected %0d", $time, what, actual, expected);
      $display("test failed");
      $fatal(1, "activation mismatch");
    end
  endtask

  task automatic check_handshake(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("FAIL %0t: %s, got %b, expected %b", $time, what, actual, expected);
      $display("test failed");
      $fatal(1, "handshake mismatch");
    end
  endtask

  ////////////////////
  // stimulus building
  ////////////////////

  task automatic add_tap(input int feat, input int weight, input int bias, input bit last,
                         input int phase);
    conv_pkg::tap_t t;
    t.feat   = conv_pkg::data_t'(feat);
    t.weight = conv_pkg::data_t'(weight);
    t.bias   = conv_pkg::data_t'(bias);
    t.last   = last;
    stim_q.push_back(t);
    phase_q.push_back(phase);
    if (last) windows_total++;
  endtask

  task automatic add_single_window(input int feat, input int weight, input int bias);
    add_tap(feat, weight, bias, 1'b1, 0);
  endtask

  task automatic build_stimulus;
    int p;
    int n;
    int k;
    int len;
    // small positives, zero bias
    add_single_window(8, 8, 0);
    add_single_window(16, 12, 0);
    add_single_window(40, 30, 0);
    add_single_window(60, 70, 0);
    // sign combinations and zero operands
    add_single_window(-128, -128, 0);
    add_single_window(-128, 127, 0);
    add_single_window(127, -128, 0);
    add_single_window(127, 127, 0);
    add_single_window(-5, -100, 0);
    add_single_window(-90, -80, 0);
    add_single_window(-1, -1, 0);
    add_single_window(0, -128, 0);
    add_single_window(-128, 0, 0);
    add_single_window(0, 0, 0);
    // clamping with large biases
    add_single_window(10, 10, -1);
    add_single_window(0, 0, 127);
    add_single_window(1, 64, 127);
    add_single_window(-128, -128, -128);
    add_single_window(-50, 60, 100);
    add_single_window(100, 90, -128);
    add_single_window(20, 20, -7);
    add_single_window(0, 0, -128);
    for (p = 1; p <= 2; p++) begin
      for (n = 0; n < 40; n++) begin
        len = 1 + (($random(seed) & 32'h7fff_ffff) % 9);
        for (k = 0; k < len; k++) begin
          add_tap($random(seed), $random(seed) % 24, $random(seed), k == len - 1, p);
        end
      end
    end
    stim_ready = 1'b1;
  endtask

  // collects a transferred tap; a last tap closes the window
  task automatic note_tap(input conv_pkg::tap_t t);
    win_feat[win_len]   = t.feat;
    win_weight[win_len] = t.weight;
    win_len++;
    if (t.last) begin
      exp_q.push_back(expected_act(win_feat, win_weight, win_len, t.bias));
      win_len = 0;
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : main
    int idx;
    bit fire;
    bit gap;
    rstn      = 1'b0;
    in_tap    = '0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    build_stimulus();
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    repeat (6) begin  // idle after reset
      @(negedge clk);
      check_handshake(out_valid, 1'b0, "out_valid after reset");
      check_handshake(in_ready, 1'b1, "in_ready after reset");
    end
    idx = 0;
    while (idx < stim_q.size()) begin
      @(negedge clk);
      fire = in_valid && in_ready;  // transfers on the coming edge
      if (fire) note_tap(in_tap);
      @(posedge clk);
      if (fire) idx++;
      if (fire || !in_valid) begin
        gap = idx < stim_q.size() && phase_q[idx] != 0 && ($random(seed) % 4 == 0);
        if (idx < stim_q.size() && !gap) begin
          in_tap   <= stim_q[idx];
          in_valid <= 1'b1;
        end else begin
          in_valid <= 1'b0;
        end
      end
      if (idx < stim_q.size() && phase_q[idx] == 2) begin
        out_ready <= ($random(seed) % 2 != 0);
      end else begin
        out_ready <= 1'b1;
      end
    end
    wait (outputs_seen == windows_total);
    repeat (20) @(posedge clk);  // catch stray outputs
    $display("test passed");
    $finish;
  end

  ////////////////////
  // compare and watchdog
  ////////////////////

  initial begin : compare
    bit             held_valid;
    conv_pkg::act_t held_act;
    held_valid = 1'b0;
    forever begin
      @(negedge clk);
      if (rstn) begin
        if (held_valid) begin  // stalled last cycle so the output must hold
          check_handshake(out_valid, 1'b1, "out_valid dropped during stall");
          check_act(out_act, held_act, "out_act changed during stall");
        end
        if (out_valid && !out_ready) begin
          check_handshake(in_ready, 1'b0, "in_ready during stall");
        end
        if (out_valid && out_ready) begin
          if (exp_q.size() == 0) begin
            $display("an output arrived with no window pending at %0t", $time);
            $display("test failed");
            $fatal(1, "unexpected output");
          end
          check_act(out_act, exp_q.pop_front(), "window result");
          outputs_seen++;
        end
        held_valid = out_valid && !out_ready;
        held_act   = out_act;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (stim_ready);
    limit = stim_q.size() * 40 + 200;
    repeat (limit) @(posedge clk);
    $display("outputs stopped arriving, %0d of %0d windows seen after %0d cycles",
             outputs_seen, windows_total, limit);
    $display("test failed");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+test
hw/conv_pkg.sv
hw/cla_block4.sv
hw/cla_adder.sv
hw/mag_multiplier.sv
hw/mac_accumulator.sv
hw/bias_relu_quant.sv
hw/conv_mac_top.sv
test/conv_mac_tb.sv
